// File: design/qspi_pkg.sv
package qspi_pkg;

    //--------------------------------------------------------------------------
    // lane and opcode encodings
    //--------------------------------------------------------------------------

    localparam int DQ_W    = 4;  // flash data lanes dq3..dq0
    localparam int DUMMY_W = 4;  // dummy clock count, also wide enough for 8 beats

    typedef enum logic [1:0] {
        lane_single = 2'd0,  // dq0 out, dq1 in
        lane_dual   = 2'd1,  // dq1..dq0
        lane_quad   = 2'd2   // dq3..dq0
    } lane_mode_e;

    typedef enum logic [1:0] {
        op_write = 2'd0,
        op_read  = 2'd1,
        op_dummy = 2'd2
    } op_e;

    //--------------------------------------------------------------------------
    // host side command and response
    //--------------------------------------------------------------------------

    typedef struct packed {
        op_e                op;
        lane_mode_e         mode;
        logic               last;        // raise chip select afterwards
        logic [7:0]         data;        // write byte
        logic [DUMMY_W-1:0] dummy_clks;  // beats for op_dummy
    } qspi_cmd_t;

    typedef struct packed {
        logic       done;  // one cycle
        logic [7:0] data;  // last read byte
    } qspi_rsp_t;

    // shift word, seen as a byte or as two nibbles
    // dual mode walks the byte view two bits at a time
    typedef union packed {
        logic [7:0]      plain;
        logic [1:0][3:0] quad;   // quad[1] goes out first
    } lane_word_u;

    // beats needed to move one byte in a given mode
    function automatic logic [DUMMY_W-1:0] lane_beats(lane_mode_e mode);
        case (mode)
            lane_dual: return DUMMY_W'(4);
            lane_quad: return DUMMY_W'(2);
            default:   return DUMMY_W'(8);
        endcase
    endfunction

endpackage

// File: design/sclk_gen.sv
module sclk_gen #(
    parameter int DIV_W = 13
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             run_i,
    input  logic [DIV_W-1:0] div_rate_i,   // even, 4 or more
    output logic             sclk_o,
    output logic             fall_en_o,
    output logic             rise_en_o
);

    //--------------------------------------------------------------------------
    // period counter
    //--------------------------------------------------------------------------

    logic [DIV_W-1:0] cnt;    // position inside one serial period
    logic [DIV_W-1:0] half;   // cycles per sclk phase
    logic [DIV_W-1:0] last;   // final count of a period

    assign half = div_rate_i >> 1;
    assign last = div_rate_i - 1'b1;

    // parked at the period end while stopped, so the first
    // running cycle rolls over to zero and announces a fall
    always_ff @(posedge clk)
    begin
        if (reset || !run_i)
            cnt <= last;
        else if (cnt == last)
            cnt <= '0;               // wrap, next period
        else
            cnt <= cnt + 1'b1;
    end

    //--------------------------------------------------------------------------
    // edge enables
    //--------------------------------------------------------------------------

    // both enables lead the registered sclk by one cycle, they mark
    // the clk edge at which sclk_o changes
    // they look at the counter only, the controller may drop run
    // in the same cycle without a loop
    assign fall_en_o = (cnt == '0);    // low phase starts next
    assign rise_en_o = (cnt == half);  // high phase starts next

    //--------------------------------------------------------------------------
    // serial clock
    //--------------------------------------------------------------------------

    // low for counts 0 .. half-1 of a running period, high otherwise
    // stopping mid period brings the clock straight back high
    always_ff @(posedge clk)
    begin
        if (reset)
            sclk_o <= 1'b1;              // idle high
        else
            sclk_o <= !(run_i && (cnt < half));
    end

endmodule

// File: design/xfer_ctrl.sv
module xfer_ctrl import qspi_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       cmd_valid_i,
    input  qspi_cmd_t  cmd_i,
    input  logic       fall_en_i,
    input  logic       rise_en_i,
    output logic       run_o,      // to sclk_gen
    output logic       cs_n_o,
    output logic       busy_o,
    output logic       done_o,
    output logic       load_o,     // capture write byte
    output logic       shift_o,    // next tx group
    output logic       sample_o,   // take rx group
    output lane_mode_e mode_o,
    output logic       drive_o,    // lanes enabled
    output logic       read_o      // read in progress
);

    typedef enum logic [2:0] {
        st_idle,       // cs high
        st_select,     // wait for first falling edge
        st_dummy,
        st_write,
        st_read,
        st_hold,       // between commands, cs kept low
        st_deselect    // half period before cs rises
    } state_e;

    state_e             state;
    op_e                op_q;
    lane_mode_e         mode_q;
    logic               last_q;
    logic [DUMMY_W-1:0] beat_cnt;   // beats still to go
    logic               beating;    // sclk edges are counted
    logic               accept;
    logic               finish;

    //--------------------------------------------------------------------------
    // decode
    //--------------------------------------------------------------------------

    assign beating = (state == st_dummy) || (state == st_write) || (state == st_read);
    assign busy_o  = beating || (state == st_select);
    assign accept  = cmd_valid_i && !busy_o;   // strobes while busy are lost

    // last beat seen on its rising edge, or nothing to do at all
    assign finish = (beating && rise_en_i && (beat_cnt == DUMMY_W'(1)))
                 || ((state == st_select) && (beat_cnt == '0));

    always_comb
    begin
        case (state)
            st_select, st_dummy, st_write, st_read:
                run_o = 1'b1;
            st_deselect:
                run_o = !fall_en_i;  // stop before the next fall would happen
            default:
                run_o = 1'b0;
        endcase
    end

    assign load_o   = accept;
    assign shift_o  = (state == st_write) && fall_en_i;
    assign sample_o = (state == st_read) && rise_en_i;
    assign read_o   = (state == st_read);
    assign mode_o   = mode_q;

    // lanes stay driven through the done cycle, past the final rising edge
    assign drive_o = (state == st_write) || (done_o && (op_q == op_write));

    //--------------------------------------------------------------------------
    // command capture
    //--------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            op_q   <= cmd_i.op;
            mode_q <= cmd_i.mode;
            last_q <= cmd_i.last;
        end
    end

    //--------------------------------------------------------------------------
    // transfer FSM
    //--------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= st_idle;
            cs_n_o   <= 1'b1;
            done_o   <= 1'b0;
            beat_cnt <= '0;
        end
        else
        begin
            done_o <= finish;   // one clk after the last rise enable
            case (state)
                st_idle, st_hold, st_deselect:
                begin
                    if (accept)
                    begin
                        state  <= st_select;
                        cs_n_o <= 1'b0;
                        if (cmd_i.op == op_dummy)
                            beat_cnt <= cmd_i.dummy_clks;
                        else
                            beat_cnt <= lane_beats(cmd_i.mode);
                    end
                    else if ((state == st_deselect) && fall_en_i)
                    begin
                        state  <= st_idle;
                        cs_n_o <= 1'b1;   // half period after done
                    end
                end

                st_select:
                begin
                    if (finish)
                        state <= last_q ? st_deselect : st_hold;   // zero dummy clocks
                    else if (fall_en_i)
                    begin
                        case (op_q)
                            op_write: state <= st_write;
                            op_read:  state <= st_read;
                            default:  state <= st_dummy;
                        endcase
                    end
                end

                default:   // dummy, write, read
                begin
                    if (finish)
                        state <= last_q ? st_deselect : st_hold;
                    else if (rise_en_i)
                        beat_cnt <= beat_cnt - 1'b1;
                end
            endcase
        end
    end

endmodule

// File: design/lane_shifter.sv
module lane_shifter import qspi_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            load_i,
    input  logic            shift_i,
    input  logic            sample_i,
    input  lane_mode_e      mode_i,
    input  logic            drive_i,
    input  logic            read_i,
    input  logic [7:0]      data_i,
    input  logic [DQ_W-1:0] dq_i,
    output logic [DQ_W-1:0] dq_o,
    output logic [DQ_W-1:0] dq_oe_o,
    output logic [7:0]      rd_data_o
);

    lane_word_u tx_word;     // msb group on the pins
    lane_word_u rx_word;     // fills from the lsb side
    logic [7:0] rd_hold;     // last finished read
    logic       read_q;
    logic       read_fall;   // first cycle after a read

    //--------------------------------------------------------------------------
    // transmit
    //--------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (load_i)
            tx_word.plain <= data_i;   // plain order, no interleave
        else if (shift_i)
        begin
            case (mode_i)
                lane_dual: tx_word.plain <= {tx_word.plain[5:0], 2'b00};
                lane_quad: tx_word.quad  <= {tx_word.quad[0], 4'b0000};
                default:   tx_word.plain <= {tx_word.plain[6:0], 1'b0};
            endcase
        end
    end

    // top group onto the low lanes, highest lane takes the highest bit
    // unused lanes are parked at zero and left disabled
    always_comb
    begin
        case (mode_i)
            lane_dual:
            begin
                dq_o    = {2'b00, tx_word.plain[7:6]};   // dq1 = bit 7
                dq_oe_o = {2'b00, {2{drive_i}}};
            end
            lane_quad:
            begin
                dq_o    = tx_word.quad[1];   // dq3 = bit 7
                dq_oe_o = {DQ_W{drive_i}};
            end
            default:
            begin
                dq_o    = {3'b000, tx_word.plain[7]};   // dq0 only
                dq_oe_o = {3'b000, drive_i};
            end
        endcase
    end

    //--------------------------------------------------------------------------
    // receive
    //--------------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (sample_i)
        begin
            case (mode_i)
                lane_dual: rx_word.plain <= {rx_word.plain[5:0], dq_i[1:0]};
                lane_quad: rx_word.quad  <= {rx_word.quad[0], dq_i};
                default:   rx_word.plain <= {rx_word.plain[6:0], dq_i[1]};   // single reads dq1
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            read_q <= 1'b0;
        else
            read_q <= read_i;
    end

    assign read_fall = read_q && !read_i;

    always_ff @(posedge clk)
    begin
        if (read_fall)
            rd_hold <= rx_word.plain;
    end

    // the fresh word shows in the done cycle itself, the copy
    // holds it while the next read refills rx_word
    assign rd_data_o = read_fall ? rx_word.plain : rd_hold;

endmodule

// File: design/qspi_byte_engine.sv
module qspi_byte_engine import qspi_pkg::*; #(
    parameter int DIV_W = 13
) (
    input  logic             clk,
    input  logic             reset,

    // host
    input  logic             cmd_valid_i,
    input  qspi_cmd_t        cmd_i,
    input  logic [DIV_W-1:0] div_rate_i,
    output logic             busy_o,
    output qspi_rsp_t        rsp_o,

    // flash
    output logic             sclk_o,
    output logic             cs_n_o,
    output logic [DQ_W-1:0]  dq_o,
    output logic [DQ_W-1:0]  dq_oe_o,
    input  logic [DQ_W-1:0]  dq_i
);

    logic       run;
    logic       fall_en;
    logic       rise_en;
    logic       done;
    logic       load;
    logic       shift;
    logic       sample;
    lane_mode_e mode;
    logic       drive;
    logic       read;
    logic [7:0] rd_data;

    //--------------------------------------------------------------------------
    // serial clock
    //--------------------------------------------------------------------------

    sclk_gen #(
        .DIV_W (DIV_W)
    ) sclk_gen_inst (
        .clk        (clk),
        .reset      (reset),
        .run_i      (run),
        .div_rate_i (div_rate_i),
        .sclk_o     (sclk_o),
        .fall_en_o  (fall_en),
        .rise_en_o  (rise_en)
    );

    //--------------------------------------------------------------------------
    // sequencing and datapath
    //--------------------------------------------------------------------------

    xfer_ctrl xfer_ctrl_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .fall_en_i   (fall_en),
        .rise_en_i   (rise_en),
        .run_o       (run),
        .cs_n_o      (cs_n_o),
        .busy_o      (busy_o),
        .done_o      (done),
        .load_o      (load),
        .shift_o     (shift),
        .sample_o    (sample),
        .mode_o      (mode),
        .drive_o     (drive),
        .read_o      (read)
    );

    lane_shifter lane_shifter_inst (
        .clk       (clk),
        .reset     (reset),
        .load_i    (load),
        .shift_i   (shift),
        .sample_i  (sample),
        .mode_i    (mode),
        .drive_i   (drive),
        .read_i    (read),
        .data_i    (cmd_i.data),   // taken on the accept cycle
        .dq_i      (dq_i),
        .dq_o      (dq_o),
        .dq_oe_o   (dq_oe_o),
        .rd_data_o (rd_data)
    );

    assign rsp_o = '{done: done, data: rd_data};

endmodule

// File: test/qspi_byte_engine_checker.sv
module qspi_byte_engine_checker import qspi_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            sclk_i,
    input  logic            cs_n_i,
    input  logic [DQ_W-1:0] dq_oe_i,
    input  logic            busy_i,
    input  qspi_rsp_t       rsp_i
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // read by the testbench at the end

    // ---------------------------------------------------------------------------
    // flash pins
    // ---------------------------------------------------------------------------

    lanes_off_deselected: assert property (@(posedge clk) disable iff (reset)
        cs_n_i |-> (dq_oe_i == '0))
    else
    begin
        $error("dq_oe_o set while cs_n_o high");
        fail_count++;
    end

    sclk_idle_deselected: assert property (@(posedge clk) disable iff (reset)
        cs_n_i |-> sclk_i)
    else
    begin
        $error("sclk_o low while cs_n_o high");
        fail_count++;
    end

    // ---------------------------------------------------------------------------
    // host side
    // ---------------------------------------------------------------------------

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        rsp_i.done |=> !rsp_i.done)
    else
    begin
        $error("rsp_o.done longer than one cycle");
        fail_count++;
    end

    idle_after_done: assert property (@(posedge clk) disable iff (reset)
        rsp_i.done |=> !busy_i)
    else
    begin
        $error("busy_o high in the cycle after done");
        fail_count++;
    end

endmodule

// File: test/qspi_byte_engine_tb.sv
module qspi_byte_engine_tb import qspi_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DIV_W    = 13;
    localparam int WAIT_MAX = 2000;   // clk cycles per wait

    logic             clk;
    logic             reset;
    logic             cmd_valid;
    qspi_cmd_t        cmd;
    logic [DIV_W-1:0] div_rate;
    logic             busy;
    qspi_rsp_t        rsp;
    logic             sclk;
    logic             cs_n;
    logic [DQ_W-1:0]  dq_out;
    logic [DQ_W-1:0]  dq_oe;
    logic [DQ_W-1:0]  dq_in = '0;

    integer     seed;
    int         errors, checks, tests, mark;
    lane_mode_e cur_mode;          // lane order the model works in
    logic       rd_active = 1'b0;  // model serves rd_byte
    logic [7:0] rd_byte;
    logic [7:0] wr_byte;           // rebuilt from dq_o
    logic [3:0] oe_or, oe_and, exp_mask;
    int         rd_idx, rises, exp_beats, dones, cs_rises, phases, phase_len;
    logic       phase_valid = 1'b0;
    logic       sclk_q = 1'b1;
    logic       cs_q = 1'b1;

    initial clk = 1'b0;
    always #4 clk = ~clk;

    qspi_byte_engine #(.DIV_W (DIV_W)) qspi_byte_engine_inst (
        .clk (clk), .reset (reset), .cmd_valid_i (cmd_valid), .cmd_i (cmd),
        .div_rate_i (div_rate), .busy_o (busy), .rsp_o (rsp), .sclk_o (sclk),
        .cs_n_o (cs_n), .dq_o (dq_out), .dq_oe_o (dq_oe), .dq_i (dq_in)
    );

    bind qspi_byte_engine qspi_byte_engine_checker checker_inst (
        .clk (clk), .reset (reset), .sclk_i (sclk_o), .cs_n_i (cs_n_o),
        .dq_oe_i (dq_oe_o), .busy_i (busy_o), .rsp_i (rsp_o)
    );

    // ---------------------------------------------------------------------------
    // flash model, looks 2 ns after each clk edge once sclk_o has settled
    // ---------------------------------------------------------------------------

    always @(posedge clk)
    begin
        #2;
        if (!reset && (sclk != sclk_q))
        begin
            if (phase_valid)   // first fall ends an idle phase, not timed
            begin
                compare("sclk_o phase", phase_len, div_rate / 2);
                phases++;
            end
            phase_len   = 1;
            phase_valid = 1'b1;
            if (sclk)   // rising edge, flash takes the driven lanes
            begin
                rises++;
                oe_or  |= dq_oe;
                oe_and &= dq_oe;
                case (cur_mode)
                    lane_dual: wr_byte = {wr_byte[5:0], dq_out[1:0]};
                    lane_quad: wr_byte = {wr_byte[3:0], dq_out};
                    default:   wr_byte = {wr_byte[6:0], dq_out[0]};
                endcase
            end
            else if (rd_active)   // falling edge, next group out, unused lanes high
            begin
                case (cur_mode)
                    lane_dual: dq_in = {2'b11, rd_byte[7 - 2 * rd_idx -: 2]};
                    lane_quad: dq_in = rd_byte[7 - 4 * rd_idx -: 4];
                    default:   dq_in = {2'b11, rd_byte[7 - rd_idx], 1'b1};
                endcase
                rd_idx++;
            end
        end
        else
            phase_len++;
        if (!busy)
            phase_valid = 1'b0;   // hold and idle phases have no fixed length
        if (rsp.done)
            dones++;
        if (cs_n && !cs_q)
            cs_rises++;
        sclk_q = sclk;
        cs_q   = cs_n;
    end

    // ---------------------------------------------------------------------------
    // helpers
    // ---------------------------------------------------------------------------

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout: %s", what);
    endtask

    function automatic qspi_cmd_t build_cmd(op_e op, lane_mode_e mode, logic last,
                                            logic [7:0] data, logic [DUMMY_W-1:0] clks);
        return '{op: op, mode: mode, last: last, data: data, dummy_clks: clks};
    endfunction

    // expected lanes and beats per mode, clears the model record
    task automatic start_beats(input lane_mode_e mode);
        cur_mode  = mode;
        exp_mask  = (mode == lane_quad) ? 4'hF : (mode == lane_dual) ? 4'h3 : 4'h1;
        exp_beats = (mode == lane_quad) ? 2 : (mode == lane_dual) ? 4 : 8;
        rises     = 0;
        rd_idx    = 0;
        wr_byte   = '0;
        oe_or     = '0;
        oe_and    = '1;
    endtask

    task automatic send_cmd(input qspi_cmd_t c);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            #1;
            n++;
        end
        while (busy && n < WAIT_MAX);
        if (busy)
            report_timeout("engine stayed busy");
        cmd       = c;
        cmd_valid = 1'b1;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;   // accepted on that edge
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (!rsp.done && n < WAIT_MAX);
        if (!rsp.done)
            report_timeout("no done pulse from the engine");
    endtask

    // counts clk cycles from done until chip select is high
    task automatic wait_cs_high(output int n);
        n = 0;
        while (!cs_n && n < WAIT_MAX)
        begin
            @(negedge clk);
            n++;
        end
        if (!cs_n)
            report_timeout("chip select never went high");
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %-20s %0d errors", name, errors - mark);
        mark = errors;
    endtask

    // ---------------------------------------------------------------------------
    // directed tests
    // ---------------------------------------------------------------------------

    task automatic write_byte(input lane_mode_e mode, input logic [7:0] data);
        int n;
        start_beats(mode);
        send_cmd(build_cmd(op_write, mode, 1'b1, data, '0));
        wait_done();
        compare("write beats", rises, exp_beats);
        compare("dq_o byte", wr_byte, data);
        compare("dq_oe_o any", oe_or, exp_mask);    // no extra lane
        compare("dq_oe_o all", oe_and, exp_mask);   // on every beat
        wait_cs_high(n);
    endtask

    task automatic read_byte(input lane_mode_e mode);
        int n;
        rd_byte = 8'($random(seed));
        start_beats(mode);
        rd_active = 1'b1;
        send_cmd(build_cmd(op_read, mode, 1'b1, 8'h00, '0));
        wait_done();
        compare("rsp_o.data", rsp.data, rd_byte);
        compare("read beats", rises, exp_beats);
        compare("dq_oe_o", oe_or, 4'h0);
        rd_active = 1'b0;
        wait_cs_high(n);
    endtask

    task automatic dummy_clocks(input logic [DIV_W-1:0] rate, input int exp_phases);
        int n;
        @(posedge clk);
        #1;
        div_rate = rate;   // only while deselected
        phases   = 0;
        start_beats(lane_single);
        send_cmd(build_cmd(op_dummy, lane_single, 1'b1, 8'h00, 4'd6));
        wait_done();
        compare("dummy sclk rises", rises, 6);
        compare("dq_oe_o", oe_or, 4'h0);
        compare("sclk_o phases", phases, exp_phases);
        wait_cs_high(n);
    endtask

    task automatic cs_framing();
        int n;
        start_beats(lane_quad);
        dones    = 0;
        cs_rises = 0;
        send_cmd(build_cmd(op_write, lane_quad, 1'b0, 8'hA5, '0));
        wait_done();
        compare("cs_n_o between", cs_n, 1'b0);
        send_cmd(build_cmd(op_write, lane_quad, 1'b1, 8'h3C, '0));
        @(posedge clk);
        #1;
        compare("busy_o", busy, 1'b1);
        cmd       = build_cmd(op_dummy, lane_single, 1'b1, 8'h00, 4'd3);
        cmd_valid = 1'b1;   // dropped, engine is busy
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        wait_done();
        compare("cs_n_o at done", cs_n, 1'b0);
        wait_cs_high(n);
        compare("cs_n_o delay", n, div_rate / 2);
        for (int i = 0; i < 4 * div_rate; i++)   // a stray accept would show here
            @(posedge clk);
        compare("done pulses", dones, 2);
        compare("cs_n_o rises", cs_rises, 1);
    endtask

    initial
    begin
        seed      = 61;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        mark      = 0;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        div_rate  = 13'd8;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        compare("cs_n_o after reset", cs_n, 1'b1);
        compare("sclk_o after reset", sclk, 1'b1);
        compare("busy_o after reset", busy, 1'b0);
        report_test("reset state");
        write_byte(lane_single, 8'hB2);
        report_test("single write");
        write_byte(lane_dual, 8'($random(seed)));
        write_byte(lane_quad, 8'($random(seed)));
        report_test("dual and quad write");
        read_byte(lane_single);
        read_byte(lane_dual);
        read_byte(lane_quad);
        report_test("reads");
        dummy_clocks(13'd8, 11);   // 12 edges, the first is untimed
        report_test("dummy clocks");
        cs_framing();
        report_test("chip select");
        dummy_clocks(13'd4, 11);
        dummy_clocks(13'd10, 11);
        report_test("divider");
        compare("assertion failures", qspi_byte_engine_inst.checker_inst.fail_count, 0);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: qspi_byte_engine.f
design/qspi_pkg.sv
design/sclk_gen.sv
design/xfer_ctrl.sv
design/lane_shifter.sv
design/qspi_byte_engine.sv
test/qspi_byte_engine_checker.sv
test/qspi_byte_engine_tb.sv
